//--- pause_demux_defines.svh
`ifndef PAUSE_DEMUX_DEFINES_SVH
`define PAUSE_DEMUX_DEFINES_SVH

// Number of downstream pause ports behind the demultiplexer.
`define PAUSE_NO_SLVS 8

// Downstream ordering.
// A value of 1 moves every port at once.
// A value of 0 walks the ports one at a time.
`define PAUSE_PARALLEL 1

`endif

//--- pause_types_pkg.sv
`default_nettype none

`include "pause_demux_defines.svh"

package pause_types_pkg;

    // One bit per downstream pause port.
    typedef logic [`PAUSE_NO_SLVS-1:0] pause_vec_t;

    // Index of one downstream port.
    typedef logic [$clog2(`PAUSE_NO_SLVS)-1:0] pause_idx_t;

endpackage

`default_nettype wire

//--- pause_ctrl_pkg.sv
`default_nettype none

package pause_ctrl_pkg;

    // States of the downstream request sequencer.
    typedef enum logic [1:0] {
        IDLE,
        STEP,
        WAIT_ACK
    } seq_state_t;

endpackage

`default_nettype wire

//--- pause_req_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module pause_req_sequencer
    import pause_types_pkg::*;
    import pause_ctrl_pkg::*;
#(
    parameter int NO_SLVS  = 8,
    parameter int PARALLEL = 1
) (
    input  logic       seq,
    input  logic       reset,
    input  logic       slv_req,
    input  logic       slv_ack,
    input  pause_vec_t msts_settled,
    output pause_vec_t msts_req
);

    seq_state_t state;
    pause_idx_t idx;
    pause_idx_t next_idx;
    logic       target;
    logic       start;
    logic       last_port;
    logic       all_settled;

    // A new upstream request is open while req and ack differ.
    assign start = (slv_req != slv_ack);

    assign all_settled = &msts_settled;

    // Pausing walks upward from port 0, resuming walks down from the top.
    always_comb begin
        if (target) begin
            next_idx  = idx + pause_idx_t'(1);
            last_port = (idx == pause_idx_t'(NO_SLVS - 1));
        end else begin
            next_idx  = idx - pause_idx_t'(1);
            last_port = (idx == pause_idx_t'(0));
        end
    end

    always_ff @(posedge seq) begin
        if (reset) begin
            // The system comes out of reset paused.
            state    <= IDLE;
            idx      <= '0;
            target   <= 1'b1;
            msts_req <= '1;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        target <= slv_req;
                        if (PARALLEL != 0) begin
                            msts_req <= {NO_SLVS{slv_req}};
                            state    <= WAIT_ACK;
                        end else begin
                            if (slv_req) begin
                                idx <= pause_idx_t'(0);
                            end else begin
                                idx <= pause_idx_t'(NO_SLVS - 1);
                            end
                            state <= STEP;
                        end
                    end
                end

                STEP: begin
                    // Only the port under the pointer moves.
                    msts_req[idx] <= target;
                    state         <= WAIT_ACK;
                end

                WAIT_ACK: begin
                    if (PARALLEL != 0) begin
                        if (all_settled) begin
                            state <= IDLE;
                        end
                    end else if (msts_settled[idx]) begin
                        if (last_port) begin
                            state <= IDLE;
                        end else begin
                            idx   <= next_idx;
                            state <= STEP;
                        end
                    end
                end

                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- pause_ack_tracker.sv
`timescale 1ns/1ns
`default_nettype none

module pause_ack_tracker
    import pause_types_pkg::*;
#(
    parameter int NO_SLVS = 8
) (
    input  logic       seq,
    input  logic       reset,
    input  pause_vec_t msts_req,
    input  pause_vec_t msts_ack,
    input  logic       slv_req,
    output pause_vec_t msts_settled,
    output logic       slv_ack
);

    pause_vec_t ack_q;
    logic       all_settled;
    logic       req_at_target;

    // Downstream acks are sampled once before any decision is made on them.
    always_ff @(posedge seq) begin
        if (reset) begin
            ack_q <= '1;
        end else begin
            ack_q <= msts_ack;
        end
    end

    // A port is settled when its sampled ack has caught up with its req.
    assign msts_settled = ~(ack_q ^ msts_req);

    assign all_settled = &msts_settled;

    // Every req must also sit at the upstream value.
    // Without this, a serial walk that has not reached the last port
    // would look finished.
    assign req_at_target = (msts_req == {NO_SLVS{slv_req}});

    always_ff @(posedge seq) begin
        if (reset) begin
            slv_ack <= 1'b1;
        end else if (all_settled && req_at_target) begin
            slv_ack <= slv_req;
        end
    end

endmodule

`default_nettype wire

//--- pause_demux.sv
`timescale 1ns/1ns
`default_nettype none

`include "pause_demux_defines.svh"

module pause_demux
    import pause_types_pkg::*;
#(
    parameter int NO_SLVS  = `PAUSE_NO_SLVS,
    parameter int PARALLEL = `PAUSE_PARALLEL
) (
    input  logic       seq,
    input  logic       reset,

    input  logic       slv_req,
    output logic       slv_ack,

    output pause_vec_t msts_req,
    input  pause_vec_t msts_ack
);

    pause_vec_t msts_settled;

    // The sequencer owns the downstream requests.
    pause_req_sequencer #(
        .NO_SLVS  (NO_SLVS),
        .PARALLEL (PARALLEL)
    ) pause_req_sequencer_i (
        .seq          (seq),
        .reset        (reset),
        .slv_req      (slv_req),
        .slv_ack      (slv_ack),
        .msts_settled (msts_settled),
        .msts_req     (msts_req)
    );

    // The tracker watches the downstream acks and answers upstream.
    pause_ack_tracker #(
        .NO_SLVS (NO_SLVS)
    ) pause_ack_tracker_i (
        .seq          (seq),
        .reset        (reset),
        .msts_req     (msts_req),
        .msts_ack     (msts_ack),
        .slv_req      (slv_req),
        .msts_settled (msts_settled),
        .slv_ack      (slv_ack)
    );

endmodule

`default_nettype wire

//--- pause_demux_checker.sv
`timescale 1ns/1ns
`default_nettype none

`include "pause_demux_defines.svh"

module pause_demux_checker
    import pause_types_pkg::*;
#(
    parameter int NO_SLVS  = `PAUSE_NO_SLVS,
    parameter int PARALLEL = `PAUSE_PARALLEL
) (
    input  logic       seq,
    input  logic       reset,
    input  logic       slv_req,
    input  logic       slv_ack,
    input  pause_vec_t msts_req,
    input  pause_vec_t msts_ack,
    input  logic       done,
    output int         error_count
);

    int         reset_errors = 0;
    int         req_errors   = 0;
    int         ack_errors   = 0;
    int         handshakes   = 0;
    logic       after_reset  = 1'b0;
    logic       prev_slv_req = 1'b1;
    logic       prev_slv_ack = 1'b1;
    pause_vec_t prev_req     = '1;
    pause_vec_t prev_ack     = '1;

    assign error_count = reset_errors + req_errors + ack_errors;

    // Returns the number of legal next msts_req values and fills them in.
    // Holding is always legal. A step is legal only from a fully settled
    // vector, and only toward the upstream request level.
    function automatic int legal_req_values(
        input  int         mode,
        input  logic       req_level,
        input  pause_vec_t cur_req,
        input  pause_vec_t cur_ack,
        output pause_vec_t legal [2]
    );
        pause_vec_t level_vec;
        pause_vec_t step;
        int         pick;
        level_vec = {NO_SLVS{req_level}};
        legal[0]  = cur_req;
        legal[1]  = cur_req;
        if (cur_req == level_vec || cur_req != cur_ack) begin
            return 1;
        end
        if (mode != 0) begin
            legal[1] = level_vec;
            return 2;
        end
        // Pausing takes the lowest port still open, resuming the highest.
        pick = 0;
        if (req_level) begin
            for (int k = NO_SLVS - 1; k >= 0; k--) begin
                if (!cur_req[k]) begin
                    pick = k;
                end
            end
        end else begin
            for (int k = 0; k < NO_SLVS; k++) begin
                if (cur_req[k]) begin
                    pick = k;
                end
            end
        end
        step       = cur_req;
        step[pick] = req_level;
        legal[1]   = step;
        return 2;
    endfunction

    task automatic report_req_mismatch(
        input pause_vec_t got,
        input pause_vec_t hold_value,
        input pause_vec_t step_value,
        input int         n_legal
    );
        if (n_legal > 1) begin
            $display("CHECK FAILED msts_req at %0t ns: got %h, expected %h or %h",
                     $time, got, hold_value, step_value);
        end else begin
            $display("CHECK FAILED msts_req at %0t ns: got %h, expected %h",
                     $time, got, hold_value);
        end
    endtask

    // Outputs are sampled on the rising edge, before the DUT updates them,
    // so every check compares the present value against the last cycle.
    always @(posedge seq) begin
        pause_vec_t legal [2];
        pause_vec_t level_vec;
        int         n_legal;
        logic       ack_may_move;
        if (reset) begin
            after_reset <= 1'b1;
        end else if (after_reset) begin
            after_reset <= 1'b0;
            if (msts_req != '1 || slv_ack != 1'b1) begin
                $display("CHECK FAILED reset state at %0t ns: msts_req %h slv_ack %h, expected %h %h",
                         $time, msts_req, slv_ack, {NO_SLVS{1'b1}}, 1'b1);
                reset_errors <= reset_errors + 1;
            end
        end else begin
            n_legal = legal_req_values(PARALLEL, prev_slv_req, prev_req, prev_ack, legal);
            if (msts_req != legal[0] && msts_req != legal[1]) begin
                report_req_mismatch(msts_req, legal[0], legal[1], n_legal);
                req_errors <= req_errors + 1;
            end

            level_vec    = {NO_SLVS{prev_slv_req}};
            ack_may_move = (prev_slv_req != prev_slv_ack) && (prev_req == level_vec) &&
                           (prev_ack == level_vec);
            if (slv_ack != prev_slv_ack) begin
                if (!ack_may_move || slv_ack != prev_slv_req) begin
                    $display("CHECK FAILED slv_ack at %0t ns: got %h, expected %h",
                             $time, slv_ack, prev_slv_ack);
                    ack_errors <= ack_errors + 1;
                end else if (slv_ack && $countones(msts_ack) != NO_SLVS) begin
                    $display("CHECK FAILED paused port count at %0t ns: got %h, expected %h",
                             $time, $countones(msts_ack), NO_SLVS);
                    ack_errors <= ack_errors + 1;
                end else if (!slv_ack && msts_ack != '0) begin
                    $display("CHECK FAILED msts_ack at %0t ns: got %h, expected %h",
                             $time, msts_ack, {NO_SLVS{1'b0}});
                    ack_errors <= ack_errors + 1;
                end else begin
                    handshakes <= handshakes + 1;
                end
            end
        end
        prev_slv_req <= slv_req;
        prev_slv_ack <= slv_ack;
        prev_req     <= msts_req;
        prev_ack     <= msts_ack;
    end

    initial begin
        wait (done);
        $display("Checker: %0d reset errors, %0d request errors, %0d ack errors, %0d handshakes",
                 reset_errors, req_errors, ack_errors, handshakes);
    end

endmodule

`default_nettype wire

//--- pause_demux_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "pause_demux_defines.svh"

module pause_demux_tb
    import pause_types_pkg::*;
#(
    parameter int          NO_SLVS  = `PAUSE_NO_SLVS,
    parameter int          PARALLEL = `PAUSE_PARALLEL,
    parameter int unsigned SEED     = 32'h626a
);

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 8;
    localparam int PAUSE_CYCLES    = 10;
    localparam int MAX_ACK_DELAY   = 20;
    localparam int MAX_IDLE_GAP    = 5;
    localparam int WATCHDOG_CYCLES = 4 * PAUSE_CYCLES * NO_SLVS * 25;

    logic       seq;
    logic       reset;
    logic       slv_req;
    logic       slv_ack;
    pause_vec_t msts_req;
    wire        pause_vec_t msts_ack;
    logic       done;
    int         error_count;

    always #(CLK_PERIOD / 2) seq = ~seq;

    pause_demux #(
        .NO_SLVS  (NO_SLVS),
        .PARALLEL (PARALLEL)
    ) pause_demux_i (
        .seq      (seq),
        .reset    (reset),
        .slv_req  (slv_req),
        .slv_ack  (slv_ack),
        .msts_req (msts_req),
        .msts_ack (msts_ack)
    );

    pause_demux_checker #(
        .NO_SLVS  (NO_SLVS),
        .PARALLEL (PARALLEL)
    ) pause_demux_checker_i (
        .seq         (seq),
        .reset       (reset),
        .slv_req     (slv_req),
        .slv_ack     (slv_ack),
        .msts_req    (msts_req),
        .msts_ack    (msts_ack),
        .done        (done),
        .error_count (error_count)
    );

    // Each downstream slave answers its own request after a random delay.
    // The acks start at 1 because the system leaves reset paused.
    for (genvar i = 0; i < NO_SLVS; i++) begin : responder
        logic ack_bit = 1'b1;

        assign msts_ack[i] = ack_bit;

        initial begin
            int unsigned delay;
            forever begin
                @(negedge seq);
                if (!reset && ack_bit != msts_req[i]) begin
                    delay = $urandom % (MAX_ACK_DELAY + 1);
                    repeat (delay) begin
                        @(negedge seq);
                    end
                    ack_bit = msts_req[i];
                end
            end
        end
    end

    // Moves the upstream request to a new level and waits for the ack.
    // The caller is already on a falling edge.
    task automatic drive_upstream(input logic level);
        slv_req = level;
        while (slv_ack !== level) begin
            @(negedge seq);
        end
    endtask

    task automatic idle_cycles(input int unsigned count);
        repeat (count) begin
            @(negedge seq);
        end
    endtask

    initial begin : width_check
        if (NO_SLVS != `PAUSE_NO_SLVS) begin
            $display("Port count %0d does not match the pause vector width %0d",
                     NO_SLVS, `PAUSE_NO_SLVS);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin : stimulus
        void'($urandom(SEED));
        seq       = 1'b0;
        reset     = 1'b1;
        slv_req   = 1'b1;
        done      = 1'b0;

        repeat (RESET_CYCLES) begin
            @(posedge seq);
        end
        @(negedge seq);
        reset = 1'b0;
        idle_cycles(3);

        // One pause cycle is a resume followed by a new pause.
        for (int n = 0; n < PAUSE_CYCLES; n++) begin
            drive_upstream(1'b0);
            idle_cycles($urandom % (MAX_IDLE_GAP + 1));
            drive_upstream(1'b1);
            idle_cycles($urandom % (MAX_IDLE_GAP + 1));
        end

        idle_cycles(4);
        done = 1'b1;
        @(posedge seq);
        @(negedge seq);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) begin
            @(posedge seq);
        end
        $display("Timeout: the pause cycles did not finish within %0d clock cycles",
                 WATCHDOG_CYCLES);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- pause_demux.f
+incdir+.
pause_types_pkg.sv
pause_ctrl_pkg.sv
pause_req_sequencer.sv
pause_ack_tracker.sv
pause_demux.sv
pause_demux_checker.sv
pause_demux_tb.sv

//--- Makefile
# Verilator build and run for the pause demultiplexer testbench.
# Every variable below can be overridden on the make command line.

VERILATOR ?= verilator
NO_SLVS   ?= 8
PARALLEL  ?= 1
SEED      ?= 25194

TOP       ?= pause_demux_tb
FILELIST  ?= pause_demux.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0

PASS_TEXT := All tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) \
		-GNO_SLVS=$(NO_SLVS) -GPARALLEL=$(PARALLEL) -GSEED=$(SEED) \
		-f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
